// ==== vlog.f ====
+incdir+.
io_bus_pkg.sv
frc_pkg.sv
io_frc_decode.sv
frc_counter.sv
frc_compare.sv
io_frc_rdmux.sv
io_frc.sv
io_frc_checker.sv
tb_io_frc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the timer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_io_frc \
	-f vlog.f \
	-o sim_tb_io_frc

./obj_dir/sim_tb_io_frc | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

// ==== tb_io_frc.sv ====
/*
 * Table-driven testbench of the IO bus timer, DUT io_frc.
 * Stimulus changes 1 ns after the rising edge and read data is sampled on the falling edge.
 * Counter gain is measured from the cycles between the testbench's own control writes.
 */
`timescale 1ns/1ps
`include "io_defines.svh"

module tb_io_frc
	import io_bus_pkg::*, frc_pkg::*;
();

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE, OP_MTIE} op_e;
	// where a read row takes its expected word from
	typedef enum logic [1:0] {EXP_WORD, EXP_CNT_LO, EXP_CNT_HI} exp_e;

	localparam io_data_t CTRL_START = (32'd1 << `FRC_RUN_BIT) | (32'd1 << `FRC_KEEP_BIT);
	localparam io_data_t CTRL_STOP = 32'd1 << `FRC_KEEP_BIT;
	localparam io_data_t CTRL_CLEAR = (32'd1 << `FRC_CLR_BIT) | (32'd1 << `FRC_KEEP_BIT);
	localparam io_data_t CTRL_DROP = 32'd0;
	// control read with run and flag both up
	localparam io_data_t RD_RUN_FLAG = (32'd1 << `FRC_RUN_BIT) | (32'd1 << `FRC_KEEP_BIT);
	localparam io_addr_t ADR_OUTSIDE = 14'h1234;
	localparam io_data_t COUNT_IDLE = 32'd30;
	localparam io_data_t IRQ_IDLE = 32'd10;
	localparam int unsigned MARGIN = 100;

	logic     clk;
	logic     rst_n;
	logic     io_we;
	io_addr_t io_wadr;
	io_data_t io_wdata;
	io_addr_t io_radr;
	logic     io_radr_en;
	io_data_t rdata_in;
	io_data_t rdata;
	logic     csr_mtie;
	logic     frc_irq;

	string    row_name[$];
	op_e      row_op[$];
	io_addr_t row_adr[$];
	io_data_t row_data[$];
	io_data_t row_exp[$];
	exp_e     row_src[$];
	logic     row_irq[$];

	int unsigned cyc = 0;
	int unsigned cyc_limit = 1000;
	int unsigned start_cyc;
	logic        tb_run;
	frc_val_t    gain;
	frc_val_t    cnt_base;
	io_data_t    rin_word;
	int          n_pass;
	int          n_fail;

	io_frc dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.rdata_in   (rdata_in),
		.rdata      (rdata),
		.csr_mtie   (csr_mtie),
		.frc_irq    (frc_irq)
	);

	always #10 clk = ~clk;

	// cycle count and watchdog
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= cyc_limit) begin
			$display("timeout: run did not finish within %0d cycles", cyc_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic add_row(input string name, input op_e op, input io_addr_t adr,
		input io_data_t data, input io_data_t exp, input exp_e src, input logic irq);
		row_name.push_back(name);
		row_op.push_back(op);
		row_adr.push_back(adr);
		row_data.push_back(data);
		row_exp.push_back(exp);
		row_src.push_back(src);
		row_irq.push_back(irq);
	endtask

	task automatic check_data(input string name, input io_data_t exp, input io_data_t act);
		if (act === exp) begin
			n_pass++;
			$display("ok           %s data %h", name, act);
		end else begin
			n_fail++;
			$display("CHECK FAILED %s data expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act === exp) begin
			n_pass++;
			$display("ok           %s irq %b", name, act);
		end else begin
			n_fail++;
			$display("CHECK FAILED %s irq expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input io_addr_t adr, input io_data_t data);
		io_we = 1'b1;
		io_wadr = adr;
		io_wdata = data;
		tick();
		io_we = 1'b0;
		// stamp the edge that took the control write
		if (adr == `FRC_CNTRL) begin
			if (data[`FRC_RUN_BIT]) begin
				start_cyc = cyc;
				tb_run = 1'b1;
			end else if (tb_run) begin
				gain = 64'(cyc - start_cyc);
				tb_run = 1'b0;
			end
		end
	endtask

	task automatic bus_read(input io_addr_t adr, output io_data_t data);
		io_radr_en = 1'b1;
		io_radr = adr;
		tick();
		io_radr_en = 1'b0;
		@(negedge clk);
		data = rdata;
		tick();
	endtask

	task automatic build_table();
		io_data_t v_lo;
		io_data_t v_hi;
		io_data_t c_lo;
		io_data_t c_hi;
		io_data_t v_lo2;
		io_data_t c_lo2;
		io_data_t base_lo;
		io_data_t base_hi;
		v_lo = $urandom;
		v_hi = $urandom;
		c_lo = $urandom;
		c_hi = $urandom;
		v_lo2 = $urandom;
		c_lo2 = $urandom;
		// low half a few counts below the carry
		base_lo = 32'hffff_fff0 | ($urandom & 32'h7);
		base_hi = $urandom & 32'h7fff_ffff;
		cnt_base = {base_hi, base_lo};
		add_row("rst_vallo", OP_READ, `FRC_VALLO, '0, '0, EXP_WORD, 1'b0);
		add_row("rst_valhi", OP_READ, `FRC_VALHI, '0, '0, EXP_WORD, 1'b0);
		add_row("rst_cmplo", OP_READ, `FRC_CMPLO, '0, '0, EXP_WORD, 1'b0);
		add_row("rst_cmphi", OP_READ, `FRC_CMPHI, '0, '0, EXP_WORD, 1'b0);
		add_row("rst_cntrl", OP_READ, `FRC_CNTRL, '0, '0, EXP_WORD, 1'b0);
		add_row("wr_vallo", OP_WRITE, `FRC_VALLO, v_lo, '0, EXP_WORD, 1'b0);
		add_row("wr_valhi", OP_WRITE, `FRC_VALHI, v_hi, '0, EXP_WORD, 1'b0);
		add_row("wr_cmplo", OP_WRITE, `FRC_CMPLO, c_lo, '0, EXP_WORD, 1'b0);
		add_row("wr_cmphi", OP_WRITE, `FRC_CMPHI, c_hi, '0, EXP_WORD, 1'b0);
		add_row("rd_vallo", OP_READ, `FRC_VALLO, '0, v_lo, EXP_WORD, 1'b0);
		add_row("rd_valhi", OP_READ, `FRC_VALHI, '0, v_hi, EXP_WORD, 1'b0);
		add_row("rd_cmplo", OP_READ, `FRC_CMPLO, '0, c_lo, EXP_WORD, 1'b0);
		add_row("rd_cmphi", OP_READ, `FRC_CMPHI, '0, c_hi, EXP_WORD, 1'b0);
		add_row("wr_vallo_only", OP_WRITE, `FRC_VALLO, v_lo2, '0, EXP_WORD, 1'b0);
		add_row("rd_vallo_new", OP_READ, `FRC_VALLO, '0, v_lo2, EXP_WORD, 1'b0);
		add_row("rd_valhi_kept", OP_READ, `FRC_VALHI, '0, v_hi, EXP_WORD, 1'b0);
		add_row("wr_cmplo_only", OP_WRITE, `FRC_CMPLO, c_lo2, '0, EXP_WORD, 1'b0);
		add_row("rd_cmplo_new", OP_READ, `FRC_CMPLO, '0, c_lo2, EXP_WORD, 1'b0);
		add_row("rd_cmphi_kept", OP_READ, `FRC_CMPHI, '0, c_hi, EXP_WORD, 1'b0);
		// count across the low to high carry
		add_row("wr_cnt_lo", OP_WRITE, `FRC_VALLO, base_lo, '0, EXP_WORD, 1'b0);
		add_row("wr_cnt_hi", OP_WRITE, `FRC_VALHI, base_hi, '0, EXP_WORD, 1'b0);
		add_row("wr_start", OP_WRITE, `FRC_CNTRL, CTRL_START, '0, EXP_WORD, 1'b0);
		add_row("idle_count", OP_IDLE, '0, COUNT_IDLE, '0, EXP_WORD, 1'b0);
		add_row("wr_stop", OP_WRITE, `FRC_CNTRL, CTRL_STOP, '0, EXP_WORD, 1'b0);
		add_row("rd_cnt_lo", OP_READ, `FRC_VALLO, '0, '0, EXP_CNT_LO, 1'b0);
		add_row("rd_cnt_hi", OP_READ, `FRC_VALHI, '0, '0, EXP_CNT_HI, 1'b0);
		add_row("rd_cntrl_stop", OP_READ, `FRC_CNTRL, '0, '0, EXP_WORD, 1'b0);
		add_row("wr_clear", OP_WRITE, `FRC_CNTRL, CTRL_CLEAR, '0, EXP_WORD, 1'b0);
		add_row("rd_clr_lo", OP_READ, `FRC_VALLO, '0, '0, EXP_WORD, 1'b0);
		add_row("rd_clr_hi", OP_READ, `FRC_VALHI, '0, '0, EXP_WORD, 1'b0);
		// compare five above the counter and csr_mtie low at first
		add_row("wr_irq_vlo", OP_WRITE, `FRC_VALLO, 32'd100, '0, EXP_WORD, 1'b0);
		add_row("wr_irq_clo", OP_WRITE, `FRC_CMPLO, 32'd105, '0, EXP_WORD, 1'b0);
		add_row("wr_irq_chi", OP_WRITE, `FRC_CMPHI, 32'd0, '0, EXP_WORD, 1'b0);
		add_row("wr_run_nomtie", OP_WRITE, `FRC_CNTRL, CTRL_START, '0, EXP_WORD, 1'b0);
		add_row("idle_nomtie", OP_IDLE, '0, IRQ_IDLE, '0, EXP_WORD, 1'b0);
		add_row("wr_stop_nomtie", OP_WRITE, `FRC_CNTRL, CTRL_STOP, '0, EXP_WORD, 1'b0);
		add_row("rd_cntrl_noflag", OP_READ, `FRC_CNTRL, '0, '0, EXP_WORD, 1'b0);
		add_row("mtie_on", OP_MTIE, '0, 32'd1, '0, EXP_WORD, 1'b0);
		add_row("wr_reload_vlo", OP_WRITE, `FRC_VALLO, 32'd100, '0, EXP_WORD, 1'b0);
		add_row("wr_run_mtie", OP_WRITE, `FRC_CNTRL, CTRL_START, '0, EXP_WORD, 1'b0);
		add_row("idle_mtie", OP_IDLE, '0, IRQ_IDLE, '0, EXP_WORD, 1'b1);
		add_row("rd_cntrl_flag", OP_READ, `FRC_CNTRL, '0, RD_RUN_FLAG, EXP_WORD, 1'b1);
		add_row("wr_drop", OP_WRITE, `FRC_CNTRL, CTRL_DROP, '0, EXP_WORD, 1'b0);
		add_row("rd_cntrl_drop", OP_READ, `FRC_CNTRL, '0, '0, EXP_WORD, 1'b0);
		add_row("mtie_off", OP_MTIE, '0, 32'd0, '0, EXP_WORD, 1'b0);
		add_row("rd_outside", OP_READ, ADR_OUTSIDE, '0, rin_word, EXP_WORD, 1'b0);
	endtask

	function automatic int unsigned row_cycles(input int i);
		case (row_op[i])
			OP_READ: return 2;
			OP_IDLE: return row_data[i];
			default: return 1;
		endcase
	endfunction

	task automatic apply_row(input int i);
		io_data_t got;
		io_data_t exp;
		frc_val_t exp64;
		case (row_op[i])
			OP_WRITE: bus_write(row_adr[i], row_data[i]);
			OP_READ: begin
				bus_read(row_adr[i], got);
				exp64 = cnt_base + gain;
				case (row_src[i])
					EXP_CNT_LO: exp = exp64[31:0];
					EXP_CNT_HI: exp = exp64[63:32];
					default:    exp = row_exp[i];
				endcase
				check_data(row_name[i], exp, got);
			end
			OP_IDLE: repeat (row_data[i]) tick();
			default: begin
				csr_mtie = row_data[i][0];
				tick();
			end
		endcase
		check_irq(row_name[i], row_irq[i], frc_irq);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		io_we = 1'b0;
		io_wadr = '0;
		io_wdata = '0;
		io_radr = '0;
		io_radr_en = 1'b0;
		csr_mtie = 1'b0;
		tb_run = 1'b0;
		gain = '0;
		n_pass = 0;
		n_fail = 0;
		void'($urandom(32'h3c19));
		rin_word = $urandom;
		rdata_in = rin_word;
		build_table();
		cyc_limit = 8 + MARGIN;
		foreach (row_op[i]) cyc_limit += row_cycles(i);
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (row_op[i]) apply_row(i);
		$display("checks passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== io_frc_checker.sv ====
/*
 * Protocol assertions on the timer, bound into every io_frc instance.
 * All checks are idle while rst_n is low.
 */
`timescale 1ns/1ps

module io_frc_checker
	import io_bus_pkg::*, frc_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      csr_mtie,
	input logic      we_vallo,
	input logic      we_valhi,
	input logic      we_cmplo,
	input logic      we_cmphi,
	input frc_rsel_t rsel,
	input io_data_t  rdata,
	input io_data_t  rdata_in,
	input logic      flag
);

	// one register written per bus cycle at most
	a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({we_vallo, we_valhi, we_cmplo, we_cmphi}))
		else $error("more than one timer write strobe active");

	// read chain untouched when no timer register is selected
	a_rdata_pass: assert property (@(posedge clk) disable iff (!rst_n)
		(rsel == '0) |-> (rdata == rdata_in))
		else $error("rdata differs from rdata_in with no register selected");

	a_flag_mtie: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(flag) |-> $past(csr_mtie))
		else $error("flag rose while csr_mtie was low");

endmodule

bind io_frc io_frc_checker chk0 (
	.clk      (clk),
	.rst_n    (rst_n),
	.csr_mtie (csr_mtie),
	.we_vallo (we_vallo),
	.we_valhi (we_valhi),
	.we_cmplo (we_cmplo),
	.we_cmphi (we_cmphi),
	.rsel     (rsel),
	.rdata    (rdata),
	.rdata_in (rdata_in),
	.flag     (flag)
);

// ==== io_frc.sv ====
/*
 * Free-running timer on the IO bus, top level.
 * Single-cycle write and read strobes, no back-pressure, read data one cycle late.
 * frc_irq is the sticky reached flag and is level, not pulse.
 */
`timescale 1ns/1ps

module io_frc
	import io_bus_pkg::*, frc_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	// IO bus
	input  logic     io_we,
	input  io_addr_t io_wadr,
	input  io_data_t io_wdata,
	input  io_addr_t io_radr,
	input  logic     io_radr_en,
	input  io_data_t rdata_in,
	output io_data_t rdata,
	// CSR side
	input  logic     csr_mtie,
	output logic     frc_irq
);

	logic      we_vallo;
	logic      we_valhi;
	logic      we_cmplo;
	logic      we_cmphi;
	logic      cntr_clr;
	logic      flag_drop;
	logic      run;
	logic      flag;
	frc_rsel_t rsel;
	frc_val_t  cntr_val;
	frc_val_t  cmp_val;

	assign frc_irq = flag;

	io_frc_decode decode0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.we_vallo   (we_vallo),
		.we_valhi   (we_valhi),
		.we_cmplo   (we_cmplo),
		.we_cmphi   (we_cmphi),
		.cntr_clr   (cntr_clr),
		.flag_drop  (flag_drop),
		.run        (run),
		.rsel       (rsel)
	);

	frc_counter counter0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.cntr_clr (cntr_clr),
		.we_vallo (we_vallo),
		.we_valhi (we_valhi),
		.run      (run),
		.wdata    (io_wdata),
		.cntr_val (cntr_val)
	);

	frc_compare compare0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.we_cmplo  (we_cmplo),
		.we_cmphi  (we_cmphi),
		.wdata     (io_wdata),
		.cntr_val  (cntr_val),
		.run       (run),
		.csr_mtie  (csr_mtie),
		.flag_drop (flag_drop),
		.cmp_val   (cmp_val),
		.flag      (flag)
	);

	io_frc_rdmux rdmux0 (
		.rsel     (rsel),
		.cntr_val (cntr_val),
		.cmp_val  (cmp_val),
		.run      (run),
		.flag     (flag),
		.rdata_in (rdata_in),
		.rdata    (rdata)
	);

endmodule

// ==== io_frc_rdmux.sv ====
/*
 * Read return mux of the timer.
 * With no timer register selected the chained bus data passes straight through.
 */
`timescale 1ns/1ps
`include "io_defines.svh"

module io_frc_rdmux
	import io_bus_pkg::*, frc_pkg::*;
(
	input  frc_rsel_t rsel,
	input  frc_val_t  cntr_val,
	input  frc_val_t  cmp_val,
	input  logic      run,
	input  logic      flag,
	input  io_data_t  rdata_in,
	output io_data_t  rdata
);

	io_data_t ctrl_word;

	// control read: flag where keep was written, clear bit reads 0
	always_comb begin
		ctrl_word = '0;
		ctrl_word[`FRC_RUN_BIT]  = run;
		ctrl_word[`FRC_KEEP_BIT] = flag;
	end

	always_comb begin
		case (rsel)
			5'b00001: rdata = cntr_val[31:0];
			5'b00010: rdata = cntr_val[63:32];
			5'b00100: rdata = cmp_val[31:0];
			5'b01000: rdata = cmp_val[63:32];
			5'b10000: rdata = ctrl_word;
			// another peripheral owns this cycle
			default:  rdata = rdata_in;
		endcase
	end

endmodule

// ==== frc_compare.sv ====
/*
 * Compare register and sticky reached flag.
 * The flag sets on an unsigned 64-bit counter >= compare while running with
 * csr_mtie high; it holds until a control write with the keep bit at 0.
 */
`timescale 1ns/1ps

module frc_compare
	import io_bus_pkg::*, frc_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     we_cmplo,
	input  logic     we_cmphi,
	input  io_data_t wdata,
	input  frc_val_t cntr_val,
	input  logic     run,
	input  logic     csr_mtie,
	input  logic     flag_drop,
	output frc_val_t cmp_val,
	output logic     flag
);

	logic reached;

	// compare value, written one half at a time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp_val <= '0;
		end else if (we_cmplo) begin
			cmp_val <= {cmp_val[63:32], wdata};
		end else if (we_cmphi) begin
			cmp_val <= {wdata, cmp_val[31:0]};
		end
	end

	// both operands are unsigned types
	assign reached = (cntr_val >= cmp_val) && run && csr_mtie;

	// drop beats set when both land on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag <= 1'b0;
		end else if (flag_drop) begin
			flag <= 1'b0;
		end else if (reached) begin
			flag <= 1'b1;
		end
	end

endmodule

// ==== frc_counter.sv ====
/*
 * 64-bit free-running counter.
 * Priority per edge is clear, low load, high load, then increment.
 * A half load writes only its own 32 bits and carries no increment that cycle.
 */
`timescale 1ns/1ps

module frc_counter
	import io_bus_pkg::*, frc_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     cntr_clr,
	input  logic     we_vallo,
	input  logic     we_valhi,
	input  logic     run,
	input  io_data_t wdata,
	output frc_val_t cntr_val
);

	frc_val_t cntr_nxt;

	always_comb begin
		cntr_nxt = cntr_val;
		if (cntr_clr) begin
			cntr_nxt = '0;
		end else if (we_vallo) begin
			cntr_nxt = {cntr_val[63:32], wdata};
		end else if (we_valhi) begin
			cntr_nxt = {wdata, cntr_val[31:0]};
		end else if (run) begin
			// carry from low word into high word comes for free
			cntr_nxt = cntr_val + 64'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cntr_val <= '0;
		end else begin
			cntr_val <= cntr_nxt;
		end
	end

endmodule

// ==== io_frc_decode.sv ====
/*
 * Bus decode and control register of the timer.
 * Strobes are combinational from the bus, so a write acts on the edge that samples it.
 * Read select is delayed by one cycle to line up with the returned data.
 */
`timescale 1ns/1ps
`include "io_defines.svh"

module io_frc_decode
	import io_bus_pkg::*, frc_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      io_we,
	input  io_addr_t  io_wadr,
	input  io_data_t  io_wdata,
	input  io_addr_t  io_radr,
	input  logic      io_radr_en,
	output logic      we_vallo,
	output logic      we_valhi,
	output logic      we_cmplo,
	output logic      we_cmphi,
	output logic      cntr_clr,
	output logic      flag_drop,
	output logic      run,
	output frc_rsel_t rsel
);

	logic      we_cntrl;
	frc_rsel_t rsel_nxt;

	// write address match
	assign we_vallo = io_we && (io_wadr == `FRC_VALLO);
	assign we_valhi = io_we && (io_wadr == `FRC_VALHI);
	assign we_cmplo = io_we && (io_wadr == `FRC_CMPLO);
	assign we_cmphi = io_we && (io_wadr == `FRC_CMPHI);
	assign we_cntrl = io_we && (io_wadr == `FRC_CNTRL);

	// clear and keep only act as one-shot strobes
	assign cntr_clr  = we_cntrl && io_wdata[`FRC_CLR_BIT];
	assign flag_drop = we_cntrl && !io_wdata[`FRC_KEEP_BIT];

	// read address match, one bit per register
	assign rsel_nxt[0] = io_radr_en && (io_radr == `FRC_VALLO);
	assign rsel_nxt[1] = io_radr_en && (io_radr == `FRC_VALHI);
	assign rsel_nxt[2] = io_radr_en && (io_radr == `FRC_CMPLO);
	assign rsel_nxt[3] = io_radr_en && (io_radr == `FRC_CMPHI);
	assign rsel_nxt[4] = io_radr_en && (io_radr == `FRC_CNTRL);

	// run bit, the only stored control bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
		end else if (we_cntrl) begin
			run <= io_wdata[`FRC_RUN_BIT];
		end
	end

	// data comes back one cycle after the read strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsel <= '0;
		end else begin
			rsel <= rsel_nxt;
		end
	end

endmodule

// ==== frc_pkg.sv ====
/*
 * Types of the free-running timer.
 * Read select bit order is vallo, valhi, cmplo, cmphi, cntrl from bit 0 up.
 */
package frc_pkg;

	// full counter and compare width
	typedef logic [63:0] frc_val_t;

	// one-hot read select, at most one bit set
	typedef logic [4:0] frc_rsel_t;

endpackage

// ==== io_bus_pkg.sv ====
/*
 * Types shared by every peripheral on the IO bus.
 * Addresses are word addresses, so byte address bits 1:0 are not carried.
 */
package io_bus_pkg;

	// word address, byte address bits 15 to 2
	typedef logic [15:2] io_addr_t;

	// one bus data word, used for write data and the chained read data
	typedef logic [31:0] io_data_t;

endpackage

// ==== io_defines.svh ====
/*
 * Timer register map on the IO bus, as 14-bit word addresses (byte bits 15:2).
 * The five registers sit at consecutive words from the timer base.
 */
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// timer base word address
`define FRC_BASE 14'h3E00

// 64-bit counter value, low and high word
`define FRC_VALLO (`FRC_BASE + 14'h0)
`define FRC_VALHI (`FRC_BASE + 14'h1)

// 64-bit compare value, low and high word
`define FRC_CMPLO (`FRC_BASE + 14'h2)
`define FRC_CMPHI (`FRC_BASE + 14'h3)

// control register
`define FRC_CNTRL (`FRC_BASE + 14'h4)

// control bit positions on write
`define FRC_RUN_BIT 0
`define FRC_CLR_BIT 1
// write 0 here to drop the reached flag
// on read this position shows the flag itself
`define FRC_KEEP_BIT 2

`endif
